//--- filelist.f
hdl/obi_pkg.sv
hdl/memcopy_pkg.sv
hdl/slow_memory.sv
hdl/obi_arbiter.sv
hdl/memcopy_periph.sv
hdl/ext_device_subsys.sv
tb/tb_ext_device_subsys.sv

//--- Bender.yml
package:
  name: ext_device_subsys

sources:
  - files:
      - hdl/obi_pkg.sv
      - hdl/memcopy_pkg.sv
      - hdl/slow_memory.sv
      - hdl/obi_arbiter.sv
      - hdl/memcopy_periph.sv
      - hdl/ext_device_subsys.sv
  - target: test
    files:
      - tb/tb_ext_device_subsys.sv

//--- tb/tb_ext_device_subsys.sv
// ========================================
// Testbench for the external device subsystem
// with bus tasks, memory model and tests
// ========================================

`timescale 1ns/1ps
`default_nettype none

module tb_ext_device_subsys;

  import obi_pkg::*;
  import memcopy_pkg::*;

  localparam int GNT_LIMIT  = 20;
  localparam int RESP_LIMIT = 8;
  localparam int READ_LAT   = 2;
  localparam logic [31:0] ST_BUSY = 32'(1) << MC_BUSY_BIT;
  localparam logic [31:0] ST_DONE = 32'(1) << MC_DONE_BIT;

  logic                  clk_i = 1'b0;
  logic                  rst_i;
  logic                  core_req_i;
  logic                  core_we_i;
  logic [OBI_BE_W-1:0]   core_be_i;
  logic [OBI_ADDR_W-1:0] core_addr_i;
  logic [OBI_DATA_W-1:0] core_wdata_i;
  logic                  core_gnt_o;
  logic                  core_rvalid_o;
  logic [OBI_DATA_W-1:0] core_rdata_o;
  logic                  reg_valid_i;
  logic                  reg_write_i;
  logic [REG_ADDR_W-1:0] reg_addr_i;
  logic [OBI_DATA_W-1:0] reg_wdata_i;
  logic                  reg_ready_o;
  logic                  reg_error_o;
  logic [OBI_DATA_W-1:0] reg_rdata_o;
  logic                  memcopy_intr_o;

  // Expected memory contents, keyed by word index
  logic [31:0] ref_mem [int];
  int          checks = 0;
  int          errors = 0;
  int          tests = 0;
  int          errs_at_start = 0;
  logic        no_traffic = 1'b0;
  logic        timed_out = 1'b0;

  ext_device_subsys dut_i (.*);

  always #20 clk_i = ~clk_i;

  gnt_needs_req: assert property (@(posedge clk_i) disable iff (rst_i) core_gnt_o |-> core_req_i)
    else begin
      errors++;
      $display("Core grant was given without a core request");
    end

  // Every response must trace back to a grant two cycles earlier
  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
      core_rvalid_o |-> $past(core_gnt_o, READ_LAT))
    else begin
      errors++;
      $display("Core rvalid came without a grant two cycles before");
    end

  quiet_bus: assert property (@(posedge clk_i) disable iff (rst_i) no_traffic |-> !dut_i.mem_req)
    else begin
      errors++;
      $display("Memory saw a request during a zero size copy");
    end

  initial begin
    wait (timed_out === 1'b1);
    $display("SOME TESTS FAILED");
    $finish;
  end

  task automatic abort_run(input string what);
    $display("Timeout: %s", what);
    timed_out = 1'b1;
    wait (timed_out == 1'b0);
  endtask

  task automatic expect_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp)
      else begin
        errors++;
        $display("ERR %s expected %08h got %08h", name, exp, act);
      end
  endtask

  function automatic void mirror_write(logic [31:0] addr, logic [3:0] be, logic [31:0] data);
    int          idx;
    logic [31:0] word;
    idx  = int'(addr[8:2]);
    word = ref_mem.exists(idx) ? ref_mem[idx] : 32'hx;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        word[8*b +: 8] = data[8*b +: 8];
      end
    end
    ref_mem[idx] = word;
  endfunction

  function automatic void mirror_copy(logic [31:0] src, logic [31:0] dst, int n);
    logic [31:0] s;
    for (int i = 0; i < n; i++) begin
      s = src + 32'(4 * i);
      mirror_write(dst + 32'(4 * i), 4'hF, ref_mem[int'(s[8:2])]);
    end
  endfunction

  // Called and returns on a falling edge
  task automatic core_access(input logic we, input logic [3:0] be, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    int n;
    core_req_i   = 1'b1;
    core_we_i    = we;
    core_be_i    = be;
    core_addr_i  = addr;
    core_wdata_i = wdata;
    n = 0;
    #1;
    while (core_gnt_o !== 1'b1) begin
      n++;
      if (n > GNT_LIMIT) begin
        abort_run("core request was never granted");
      end
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    core_req_i = 1'b0;
    n = 1;
    #1;
    while (core_rvalid_o !== 1'b1) begin
      n++;
      if (n > RESP_LIMIT) begin
        abort_run("core response never came after its grant");
      end
      @(negedge clk_i);
      #1;
    end
    expect_value("core_rvalid_o latency", READ_LAT, n);
    rdata = core_rdata_o;
    @(negedge clk_i);
  endtask

  task automatic store_word(input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] data);
    logic [31:0] unused;
    core_access(1'b1, be, addr, data, unused);
    mirror_write(addr, be, data);
  endtask

  task automatic load_check(input logic [31:0] addr);
    logic [31:0] data;
    core_access(1'b0, 4'hF, addr, '0, data);
    expect_value($sformatf("core_rdata_o @%08h", addr), ref_mem[int'(addr[8:2])], data);
  endtask

  task automatic verify_region(input logic [31:0] base, input int n);
    for (int i = 0; i < n; i++) begin
      load_check(base + 32'(4 * i));
    end
  endtask

  // One register access, ready is due in the same cycle
  task automatic reg_check(input logic wr, input logic [3:0] off, input logic [31:0] wdata,
                           input logic exp_err, input logic [31:0] exp_rdata);
    reg_valid_i = 1'b1;
    reg_write_i = wr;
    reg_addr_i  = off;
    reg_wdata_i = wdata;
    #1;
    expect_value($sformatf("reg_ready_o @%h", off), 1, reg_ready_o);
    expect_value($sformatf("reg_error_o @%h", off), exp_err, reg_error_o);
    if (!wr && !exp_err) begin
      expect_value($sformatf("reg_rdata_o @%h", off), exp_rdata, reg_rdata_o);
    end
    @(negedge clk_i);
    reg_valid_i = 1'b0;
    reg_write_i = 1'b0;
  endtask

  task automatic start_copy(input logic [31:0] src, input logic [31:0] dst, input int n);
    reg_check(1'b1, MC_SRC_OFF, src, 1'b0, '0);
    reg_check(1'b1, MC_DST_OFF, dst, 1'b0, '0);
    reg_check(1'b1, MC_SIZE_OFF, 32'(n), 1'b0, '0);
  endtask

  task automatic await_intr(input int limit);
    int n;
    n = 0;
    while (memcopy_intr_o !== 1'b1) begin
      n++;
      if (n > limit) begin
        abort_run("copy interrupt never came");
      end
      @(negedge clk_i);
    end
  endtask

  task automatic report_test(input string name);
    tests++;
    if (errors == errs_at_start) begin
      $display("Test %0d %s passed", tests, name);
    end else begin
      $display("Test %0d %s failed with %0d errors", tests, name, errors - errs_at_start);
    end
    errs_at_start = errors;
  endtask

  initial begin
    logic [31:0] addr;
    int          size;
    void'($urandom(57));
    rst_i        = 1'b1;
    core_req_i   = 1'b0;
    core_we_i    = 1'b0;
    core_be_i    = '0;
    core_addr_i  = '0;
    core_wdata_i = '0;
    reg_valid_i  = 1'b0;
    reg_write_i  = 1'b0;
    reg_addr_i   = '0;
    reg_wdata_i  = '0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    expect_value("core_gnt_o", 0, core_gnt_o);
    expect_value("core_rvalid_o", 0, core_rvalid_o);
    expect_value("memcopy_intr_o", 0, memcopy_intr_o);
    reg_check(1'b0, MC_STATUS_OFF, '0, 1'b0, '0);
    reg_check(1'b0, MC_SRC_OFF, '0, 1'b0, '0);
    reg_check(1'b0, MC_DST_OFF, '0, 1'b0, '0);
    reg_check(1'b0, MC_SIZE_OFF, '0, 1'b0, '0);
    report_test("reset values");

    // Fill every word through aliased addresses, then partial writes
    for (int i = 0; i < MEM_NUM_WORDS; i++) begin
      addr = ($urandom() & 32'hFFFF_FE00) | 32'(4 * i);
      store_word(addr, 4'hF, $urandom());
    end
    repeat (40) begin
      store_word($urandom() & ~32'h3, 4'($urandom()), $urandom());
    end
    repeat (40) begin
      load_check($urandom() & ~32'h3);
    end
    report_test("core writes and reads");

    addr = $urandom() & ~32'h3;
    reg_check(1'b1, MC_SRC_OFF, addr, 1'b0, '0);
    reg_check(1'b0, MC_SRC_OFF, '0, 1'b0, addr);
    reg_check(1'b1, MC_DST_OFF, ~addr, 1'b0, '0);
    reg_check(1'b0, MC_DST_OFF, '0, 1'b0, ~addr);
    reg_check(1'b0, 4'h2, '0, 1'b1, '0);
    reg_check(1'b1, 4'h5, $urandom(), 1'b1, '0);
    reg_check(1'b1, 4'hB, $urandom(), 1'b1, '0);
    reg_check(1'b1, MC_STATUS_OFF, 32'h3, 1'b1, '0);
    reg_check(1'b0, MC_STATUS_OFF, '0, 1'b0, '0);
    reg_check(1'b0, MC_SRC_OFF, '0, 1'b0, addr);
    report_test("register access");

    size = 1 + int'($urandom() % 16);
    start_copy(32'h0000_0000, 32'h0000_0280, size);
    reg_check(1'b0, MC_STATUS_OFF, '0, 1'b0, ST_BUSY);
    reg_check(1'b1, MC_SIZE_OFF, 32'h5, 1'b1, '0);
    await_intr(400);
    reg_check(1'b0, MC_STATUS_OFF, '0, 1'b0, ST_DONE);
    expect_value("memcopy_intr_o", 0, memcopy_intr_o);
    mirror_copy(32'h0000_0000, 32'h0000_0280, size);
    verify_region(32'h0000_0080, size);
    report_test("single copy");

    // Core traffic in words 96 to 127 while the engine copies 64..79 to 80..95
    start_copy(32'h0000_0100, 32'h0000_0140, 16);
    repeat (24) begin
      addr = ($urandom() & 32'hFFFF_FE00) | (32'h180 + 32'(4 * ($urandom() % 32)));
      if ($urandom() % 2 == 0) begin
        store_word(addr, 4'($urandom()), $urandom());
      end else begin
        load_check(addr);
      end
    end
    await_intr(2000);
    reg_check(1'b0, MC_STATUS_OFF, '0, 1'b0, ST_DONE);
    mirror_copy(32'h0000_0100, 32'h0000_0140, 16);
    verify_region(32'h0000_0140, 16);
    verify_region(32'h0000_0080, size);
    report_test("copy with core traffic");

    no_traffic = 1'b1;
    reg_check(1'b1, MC_SIZE_OFF, '0, 1'b0, '0);
    expect_value("memcopy_intr_o", 1, memcopy_intr_o);
    reg_check(1'b0, MC_STATUS_OFF, '0, 1'b0, ST_DONE);
    expect_value("memcopy_intr_o", 0, memcopy_intr_o);
    no_traffic = 1'b0;
    report_test("zero size copy");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_ext_device_subsys

`default_nettype wire

//--- hdl/ext_device_subsys.sv
// ======================================
// External device subsystem top level
// ======================================

`timescale 1ns/1ps
`default_nettype none

module ext_device_subsys (
  input  wire logic                               clk_i,
  input  wire logic                               rst_i,
  // Core OBI port
  input  wire logic                               core_req_i,
  input  wire logic                               core_we_i,
  input  wire logic [obi_pkg::OBI_BE_W-1:0]       core_be_i,
  input  wire logic [obi_pkg::OBI_ADDR_W-1:0]     core_addr_i,
  input  wire logic [obi_pkg::OBI_DATA_W-1:0]     core_wdata_i,
  output logic                                    core_gnt_o,
  output logic                                    core_rvalid_o,
  output logic [obi_pkg::OBI_DATA_W-1:0]          core_rdata_o,
  // Copy peripheral registers
  input  wire logic                               reg_valid_i,
  input  wire logic                               reg_write_i,
  input  wire logic [memcopy_pkg::REG_ADDR_W-1:0] reg_addr_i,
  input  wire logic [obi_pkg::OBI_DATA_W-1:0]     reg_wdata_i,
  output logic                                    reg_ready_o,
  output logic                                    reg_error_o,
  output logic [obi_pkg::OBI_DATA_W-1:0]          reg_rdata_o,
  output logic                                    memcopy_intr_o
);

  import obi_pkg::*;

  // Copy engine master port
  logic                  mc_req;
  logic                  mc_we;
  logic [OBI_BE_W-1:0]   mc_be;
  logic [OBI_ADDR_W-1:0] mc_addr;
  logic [OBI_DATA_W-1:0] mc_wdata;
  logic                  mc_gnt;
  logic                  mc_rvalid;
  logic [OBI_DATA_W-1:0] mc_rdata;

  // Arbiter to slow memory
  logic                  mem_req;
  logic                  mem_we;
  logic [OBI_BE_W-1:0]   mem_be;
  logic [OBI_ADDR_W-1:0] mem_addr;
  logic [OBI_DATA_W-1:0] mem_wdata;
  logic                  mem_gnt;
  logic                  mem_rvalid;
  logic [OBI_DATA_W-1:0] mem_rdata;

  memcopy_periph memcopy_periph_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .reg_valid_i  (reg_valid_i),
    .reg_write_i  (reg_write_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .reg_ready_o  (reg_ready_o),
    .reg_error_o  (reg_error_o),
    .reg_rdata_o  (reg_rdata_o),
    .mst_req_o    (mc_req),
    .mst_we_o     (mc_we),
    .mst_be_o     (mc_be),
    .mst_addr_o   (mc_addr),
    .mst_wdata_o  (mc_wdata),
    .mst_gnt_i    (mc_gnt),
    .mst_rvalid_i (mc_rvalid),
    .mst_rdata_i  (mc_rdata),
    .intr_o       (memcopy_intr_o)
  );

  // Core on input 0, copy engine on input 1
  obi_arbiter obi_arbiter_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .m0_req_i    (core_req_i),
    .m0_we_i     (core_we_i),
    .m0_be_i     (core_be_i),
    .m0_addr_i   (core_addr_i),
    .m0_wdata_i  (core_wdata_i),
    .m0_gnt_o    (core_gnt_o),
    .m0_rvalid_o (core_rvalid_o),
    .m0_rdata_o  (core_rdata_o),
    .m1_req_i    (mc_req),
    .m1_we_i     (mc_we),
    .m1_be_i     (mc_be),
    .m1_addr_i   (mc_addr),
    .m1_wdata_i  (mc_wdata),
    .m1_gnt_o    (mc_gnt),
    .m1_rvalid_o (mc_rvalid),
    .m1_rdata_o  (mc_rdata),
    .s_req_o     (mem_req),
    .s_we_o      (mem_we),
    .s_be_o      (mem_be),
    .s_addr_o    (mem_addr),
    .s_wdata_o   (mem_wdata),
    .s_gnt_i     (mem_gnt),
    .s_rvalid_i  (mem_rvalid),
    .s_rdata_i   (mem_rdata)
  );

  slow_memory slow_memory_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .req_i    (mem_req),
    .we_i     (mem_we),
    .be_i     (mem_be),
    .addr_i   (mem_addr),
    .wdata_i  (mem_wdata),
    .gnt_o    (mem_gnt),
    .rvalid_o (mem_rvalid),
    .rdata_o  (mem_rdata)
  );

endmodule : ext_device_subsys

`default_nettype wire

//--- hdl/memcopy_periph.sv
// ======================================
// Register-programmed word copy engine
// with OBI master and done interrupt
// ======================================

`timescale 1ns/1ps
`default_nettype none

module memcopy_periph (
  input  wire logic                               clk_i,
  input  wire logic                               rst_i,
  // Register bus
  input  wire logic                               reg_valid_i,
  input  wire logic                               reg_write_i,
  input  wire logic [memcopy_pkg::REG_ADDR_W-1:0] reg_addr_i,
  input  wire logic [obi_pkg::OBI_DATA_W-1:0]     reg_wdata_i,
  output logic                                    reg_ready_o,
  output logic                                    reg_error_o,
  output logic [obi_pkg::OBI_DATA_W-1:0]          reg_rdata_o,
  // OBI master
  output logic                                    mst_req_o,
  output logic                                    mst_we_o,
  output logic [obi_pkg::OBI_BE_W-1:0]            mst_be_o,
  output logic [obi_pkg::OBI_ADDR_W-1:0]          mst_addr_o,
  output logic [obi_pkg::OBI_DATA_W-1:0]          mst_wdata_o,
  input  wire logic                               mst_gnt_i,
  input  wire logic                               mst_rvalid_i,
  input  wire logic [obi_pkg::OBI_DATA_W-1:0]     mst_rdata_i,
  // Copy done
  output logic                                    intr_o
);

  import obi_pkg::*;
  import memcopy_pkg::*;

  memcopy_state_e        state_q;
  logic [OBI_ADDR_W-1:0] src_q;
  logic [OBI_ADDR_W-1:0] dst_q;
  logic [OBI_DATA_W-1:0] size_q;
  logic                  done_q;
  logic                  busy;
  logic [OBI_DATA_W-1:0] status;
  // Register strobes
  logic                  wr_src;
  logic                  wr_dst;
  logic                  wr_size;
  logic                  rd_status;
  // Working copies for the running transfer
  logic [OBI_ADDR_W-1:0] rd_addr_q;
  logic [OBI_ADDR_W-1:0] wr_addr_q;
  logic [OBI_DATA_W-1:0] cnt_q;
  logic [OBI_DATA_W-1:0] data_q;

  assign busy        = (state_q != IDLE);
  assign reg_ready_o = reg_valid_i;

  always_comb begin
    status              = '0;
    status[MC_BUSY_BIT] = busy;
    status[MC_DONE_BIT] = done_q;
  end

  // Register decode, every access completes in its own cycle
  always_comb begin
    reg_error_o = 1'b0;
    reg_rdata_o = '0;
    wr_src      = 1'b0;
    wr_dst      = 1'b0;
    wr_size     = 1'b0;
    rd_status   = 1'b0;
    if (reg_valid_i) begin
      case (reg_addr_i)
        MC_SRC_OFF: begin
          reg_rdata_o = src_q;
          wr_src      = reg_write_i;
        end
        MC_DST_OFF: begin
          reg_rdata_o = dst_q;
          wr_dst      = reg_write_i;
        end
        MC_SIZE_OFF: begin
          reg_rdata_o = size_q;
          reg_error_o = reg_write_i && busy;
          wr_size     = reg_write_i && !busy;
        end
        MC_STATUS_OFF: begin
          reg_rdata_o = status;
          reg_error_o = reg_write_i;
          rd_status   = !reg_write_i;
        end
        // Unaligned offsets
        default: reg_error_o = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      src_q   <= '0;
      dst_q   <= '0;
      size_q  <= '0;
      done_q  <= 1'b0;
      state_q <= IDLE;
    end else begin
      if (wr_src) begin
        src_q <= reg_wdata_i;
      end
      if (wr_dst) begin
        dst_q <= reg_wdata_i;
      end
      if (wr_size) begin
        size_q <= reg_wdata_i;
      end
      // STATUS read or new start clears done, a finish below takes priority
      if (rd_status || wr_size) begin
        done_q <= 1'b0;
      end
      case (state_q)
        IDLE: begin
          if (wr_size) begin
            if (reg_wdata_i == '0) begin
              done_q <= 1'b1;
            end else begin
              state_q <= RD_REQ;
            end
          end
        end
        RD_REQ: begin
          if (mst_gnt_i) begin
            state_q <= RD_WAIT;
          end
        end
        RD_WAIT: begin
          if (mst_rvalid_i) begin
            state_q <= WR_REQ;
          end
        end
        WR_REQ: begin
          if (mst_gnt_i) begin
            state_q <= WR_WAIT;
          end
        end
        WR_WAIT: begin
          if (mst_rvalid_i) begin
            if (cnt_q == OBI_DATA_W'(1)) begin
              state_q <= IDLE;
              done_q  <= 1'b1;
            end else begin
              state_q <= RD_REQ;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Addresses, remaining count and the word in flight
  always_ff @(posedge clk_i) begin
    if (wr_size) begin
      rd_addr_q <= src_q;
      wr_addr_q <= dst_q;
      cnt_q     <= reg_wdata_i;
    end else if (state_q == RD_WAIT && mst_rvalid_i) begin
      data_q <= mst_rdata_i;
    end else if (state_q == WR_WAIT && mst_rvalid_i) begin
      rd_addr_q <= rd_addr_q + OBI_ADDR_W'(4);
      wr_addr_q <= wr_addr_q + OBI_ADDR_W'(4);
      cnt_q     <= cnt_q - OBI_DATA_W'(1);
    end
  end

  // Master port, whole words only
  assign mst_req_o   = (state_q == RD_REQ) || (state_q == WR_REQ);
  assign mst_we_o    = (state_q == WR_REQ);
  assign mst_be_o    = '1;
  assign mst_addr_o  = mst_we_o ? wr_addr_q : rd_addr_q;
  assign mst_wdata_o = data_q;

  assign intr_o = done_q;

endmodule : memcopy_periph

`default_nettype wire

//--- hdl/obi_arbiter.sv
// ======================================
// Two-master round-robin OBI arbiter
// ======================================

`timescale 1ns/1ps
`default_nettype none

module obi_arbiter (
  input  wire logic                            clk_i,
  input  wire logic                            rst_i,
  // Master 0
  input  wire logic                            m0_req_i,
  input  wire logic                            m0_we_i,
  input  wire logic [obi_pkg::OBI_BE_W-1:0]    m0_be_i,
  input  wire logic [obi_pkg::OBI_ADDR_W-1:0]  m0_addr_i,
  input  wire logic [obi_pkg::OBI_DATA_W-1:0]  m0_wdata_i,
  output logic                                 m0_gnt_o,
  output logic                                 m0_rvalid_o,
  output logic [obi_pkg::OBI_DATA_W-1:0]       m0_rdata_o,
  // Master 1
  input  wire logic                            m1_req_i,
  input  wire logic                            m1_we_i,
  input  wire logic [obi_pkg::OBI_BE_W-1:0]    m1_be_i,
  input  wire logic [obi_pkg::OBI_ADDR_W-1:0]  m1_addr_i,
  input  wire logic [obi_pkg::OBI_DATA_W-1:0]  m1_wdata_i,
  output logic                                 m1_gnt_o,
  output logic                                 m1_rvalid_o,
  output logic [obi_pkg::OBI_DATA_W-1:0]       m1_rdata_o,
  // Slave
  output logic                                 s_req_o,
  output logic                                 s_we_o,
  output logic [obi_pkg::OBI_BE_W-1:0]         s_be_o,
  output logic [obi_pkg::OBI_ADDR_W-1:0]       s_addr_o,
  output logic [obi_pkg::OBI_DATA_W-1:0]       s_wdata_o,
  input  wire logic                            s_gnt_i,
  input  wire logic                            s_rvalid_i,
  input  wire logic [obi_pkg::OBI_DATA_W-1:0]  s_rdata_i
);

  // Selected master for the current request
  logic sel;
  // Master granted last; it owns the pending response and loses the next tie
  logic owner_q;

  always_comb begin
    if (m0_req_i && m1_req_i) begin
      sel = ~owner_q;
    end else begin
      sel = m1_req_i;
    end
  end

  // Request path
  assign s_req_o   = m0_req_i | m1_req_i;
  assign s_we_o    = sel ? m1_we_i    : m0_we_i;
  assign s_be_o    = sel ? m1_be_i    : m0_be_i;
  assign s_addr_o  = sel ? m1_addr_i  : m0_addr_i;
  assign s_wdata_o = sel ? m1_wdata_i : m0_wdata_i;

  // Only the selected master sees the grant
  assign m0_gnt_o = s_gnt_i & ~sel;
  assign m1_gnt_o = s_gnt_i & sel;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      owner_q <= 1'b0;
    end else if (s_gnt_i) begin
      owner_q <= sel;
    end
  end

  // Response path back to the owner
  assign m0_rvalid_o = s_rvalid_i & ~owner_q;
  assign m1_rvalid_o = s_rvalid_i & owner_q;
  assign m0_rdata_o  = owner_q ? '0 : s_rdata_i;
  assign m1_rdata_o  = owner_q ? s_rdata_i : '0;

endmodule : obi_arbiter

`default_nettype wire

//--- hdl/slow_memory.sv
// ======================================
// Slow word memory with OBI slave port,
// random grant delay, fixed read delay
// ======================================

`timescale 1ns/1ps
`default_nettype none

module slow_memory (
  input  wire logic                            clk_i,
  input  wire logic                            rst_i,
  input  wire logic                            req_i,
  input  wire logic                            we_i,
  input  wire logic [obi_pkg::OBI_BE_W-1:0]    be_i,
  input  wire logic [obi_pkg::OBI_ADDR_W-1:0]  addr_i,
  input  wire logic [obi_pkg::OBI_DATA_W-1:0]  wdata_i,
  output logic                                 gnt_o,
  output logic                                 rvalid_o,
  output logic [obi_pkg::OBI_DATA_W-1:0]       rdata_o
);

  import obi_pkg::*;

  logic [OBI_DATA_W-1:0]     mem_q [MEM_NUM_WORDS];
  logic [MEM_IDX_W-1:0]      idx;
  logic [3:0]                lfsr_q;
  logic                      wait_q;
  logic [1:0]                cnt_q;
  logic [MEM_READ_DELAY-1:0] pipe_q;
  logic                      pending;

  // Higher address bits are dropped, so addresses alias
  assign idx     = addr_i[MEM_IDX_W+1:2];
  assign pending = |pipe_q;

  // Zero delay grants in the request cycle, otherwise when the count expires
  always_comb begin
    gnt_o = 1'b0;
    if (req_i && !pending) begin
      gnt_o = wait_q ? (cnt_q == 2'd0) : (lfsr_q[1:0] == 2'd0);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lfsr_q <= 4'b0001;
      wait_q <= 1'b0;
      cnt_q  <= 2'd0;
      pipe_q <= '0;
    end else begin
      // x^4 + x^3 + 1, free running
      lfsr_q <= {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]};
      // Response delay chain, one bit per cycle after the grant
      pipe_q <= {pipe_q[MEM_READ_DELAY-2:0], gnt_o};
      if (gnt_o || !req_i) begin
        wait_q <= 1'b0;
      end else if (!wait_q && !pending) begin
        // New request at an idle memory takes its delay from the LFSR
        wait_q <= 1'b1;
        cnt_q  <= lfsr_q[1:0] - 2'd1;
      end else if (wait_q) begin
        cnt_q <= cnt_q - 2'd1;
      end
    end
  end

  // Storage and read data, both sampled at the grant edge
  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      if (we_i) begin
        for (int b = 0; b < OBI_BE_W; b++) begin
          if (be_i[b]) begin
            mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[idx];
      end
    end
  end

  assign rvalid_o = pipe_q[MEM_READ_DELAY-1];

endmodule : slow_memory

`default_nettype wire

//--- hdl/memcopy_pkg.sv
// ======================================
// Copy peripheral register map, status
// bits and engine state type
// ======================================

`default_nettype none

package memcopy_pkg;

  // Register byte offset width
  localparam int REG_ADDR_W = 4;

  // Register offsets
  localparam logic [REG_ADDR_W-1:0] MC_SRC_OFF    = 4'h0;
  localparam logic [REG_ADDR_W-1:0] MC_DST_OFF    = 4'h4;
  // A write here starts the copy
  localparam logic [REG_ADDR_W-1:0] MC_SIZE_OFF   = 4'h8;
  localparam logic [REG_ADDR_W-1:0] MC_STATUS_OFF = 4'hC;

  // STATUS bit positions
  localparam int MC_BUSY_BIT = 0;
  localparam int MC_DONE_BIT = 1;

  // Copy engine states
  typedef enum logic [2:0] {
    IDLE,
    RD_REQ,
    RD_WAIT,
    WR_REQ,
    WR_WAIT
  } memcopy_state_e;

endpackage : memcopy_pkg

`default_nettype wire

//--- hdl/obi_pkg.sv
// ======================================
// OBI bus widths and slow memory geometry
// ======================================

`default_nettype none

package obi_pkg;

  // Bus widths
  localparam int OBI_ADDR_W = 32;
  localparam int OBI_DATA_W = 32;
  localparam int OBI_BE_W   = OBI_DATA_W / 8;

  // Slow memory size, word index taken from address bits 8:2
  localparam int MEM_NUM_WORDS = 128;
  localparam int MEM_IDX_W     = $clog2(MEM_NUM_WORDS);

  // Cycles from the grant cycle to rvalid
  localparam int MEM_READ_DELAY = 2;

endpackage : obi_pkg

`default_nettype wire
